// ==== rtl/axi_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_xbar #(
	parameter int ADDR_LEN = 32,
	parameter int DATA_LEN = 32
) (
	input  wire                    clock,
	input  wire                    reset_i,
	// From the access controller
	input  wire                    ctl_arvalid_i,
	input  wire [ADDR_LEN-1:0]     ctl_araddr_i,
	input  wire [7:0]              ctl_arlen_i,
	input  wire [2:0]              ctl_arsize_i,
	output logic                   ctl_arready_o,
	output logic                   ctl_rvalid_o,
	output logic [DATA_LEN-1:0]    ctl_rdata_o,
	output logic [1:0]             ctl_rresp_o,
	output logic                   ctl_rlast_o,
	input  wire                    ctl_rready_i,
	input  wire                    ctl_awvalid_i,
	input  wire [ADDR_LEN-1:0]     ctl_awaddr_i,
	input  wire [2:0]              ctl_awsize_i,
	output logic                   ctl_awready_o,
	input  wire                    ctl_wvalid_i,
	input  wire [DATA_LEN-1:0]     ctl_wdata_i,
	input  wire [DATA_LEN/8-1:0]   ctl_wstrb_i,
	input  wire                    ctl_wlast_i,
	output logic                   ctl_wready_o,
	output logic                   ctl_bvalid_o,
	output logic [1:0]             ctl_bresp_o,
	input  wire                    ctl_bready_i,
	// External master port
	output logic                   io_master_arvalid_o,
	output logic [ADDR_LEN-1:0]    io_master_araddr_o,
	output logic [7:0]             io_master_arlen_o,
	output logic [2:0]             io_master_arsize_o,
	input  wire                    io_master_arready_i,
	input  wire                    io_master_rvalid_i,
	input  wire [DATA_LEN-1:0]     io_master_rdata_i,
	input  wire [1:0]              io_master_rresp_i,
	input  wire                    io_master_rlast_i,
	output logic                   io_master_rready_o,
	output logic                   io_master_awvalid_o,
	output logic [ADDR_LEN-1:0]    io_master_awaddr_o,
	output logic [2:0]             io_master_awsize_o,
	input  wire                    io_master_awready_i,
	output logic                   io_master_wvalid_o,
	output logic [DATA_LEN-1:0]    io_master_wdata_o,
	output logic [DATA_LEN/8-1:0]  io_master_wstrb_o,
	output logic                   io_master_wlast_o,
	input  wire                    io_master_wready_i,
	input  wire                    io_master_bvalid_i,
	input  wire [1:0]              io_master_bresp_i,
	output logic                   io_master_bready_o,
	// Timer read channel
	output logic                   clint_arvalid_o,
	output logic [ADDR_LEN-1:0]    clint_araddr_o,
	input  wire                    clint_arready_i,
	input  wire                    clint_rvalid_i,
	input  wire [DATA_LEN-1:0]     clint_rdata_i,
	input  wire [1:0]              clint_rresp_i,
	input  wire                    clint_rlast_i,
	output logic                   clint_rready_o
);

	logic ar_hit;
	logic rd_busy;
	logic rd_clint;
	logic ar_fire;
	logic r_fire;

	assign ar_hit = (ctl_araddr_i & ~ADDR_LEN'(soc_pkg::CLINT_SPAN_MASK))
		== ADDR_LEN'(soc_pkg::CLINT_BASE);

	// Only one read in flight, new ar waits for the last beat
	assign clint_arvalid_o     = ctl_arvalid_i && !rd_busy && ar_hit;
	assign clint_araddr_o      = ctl_araddr_i;
	assign io_master_arvalid_o = ctl_arvalid_i && !rd_busy && !ar_hit;
	assign io_master_araddr_o  = ctl_araddr_i;
	assign io_master_arlen_o   = ctl_arlen_i;
	assign io_master_arsize_o  = ctl_arsize_i;
	assign ctl_arready_o       = !rd_busy && (ar_hit ? clint_arready_i : io_master_arready_i);
	assign ar_fire             = ctl_arvalid_i && ctl_arready_o;

	always_comb begin
		ctl_rvalid_o = 1'b0;
		ctl_rdata_o  = io_master_rdata_i;
		ctl_rresp_o  = soc_pkg::AXI_RESP_SLVERR;
		ctl_rlast_o  = 1'b0;
		if (rd_busy && rd_clint) begin
			ctl_rvalid_o = clint_rvalid_i;
			ctl_rdata_o  = clint_rdata_i;
			ctl_rresp_o  = clint_rresp_i;
			ctl_rlast_o  = clint_rlast_i;
		end else if (rd_busy) begin
			ctl_rvalid_o = io_master_rvalid_i;
			ctl_rresp_o  = io_master_rresp_i;
			ctl_rlast_o  = io_master_rlast_i;
		end
	end

	assign io_master_rready_o = rd_busy && !rd_clint && ctl_rready_i;
	assign clint_rready_o     = rd_busy && rd_clint && ctl_rready_i;
	assign r_fire             = ctl_rvalid_o && ctl_rready_i;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			rd_busy  <= 1'b0;
			rd_clint <= 1'b0;
		end else if (ar_fire) begin
			rd_busy  <= 1'b1;
			rd_clint <= ar_hit;
		end else if (r_fire && ctl_rlast_o) begin
			rd_busy <= 1'b0;
		end
	end

	// Writes always leave through the external port
	assign io_master_awvalid_o = ctl_awvalid_i;
	assign io_master_awaddr_o  = ctl_awaddr_i;
	assign io_master_awsize_o  = ctl_awsize_i;
	assign ctl_awready_o       = io_master_awready_i;
	assign io_master_wvalid_o  = ctl_wvalid_i;
	assign io_master_wdata_o   = ctl_wdata_i;
	assign io_master_wstrb_o   = ctl_wstrb_i;
	assign io_master_wlast_o   = ctl_wlast_i;
	assign ctl_wready_o        = io_master_wready_i;
	assign ctl_bvalid_o        = io_master_bvalid_i;
	assign ctl_bresp_o         = io_master_bresp_i;
	assign io_master_bready_o  = ctl_bready_i;

endmodule

`default_nettype wire

// ==== rtl/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
	parameter int ADDR_LEN = 32,
	parameter int DATA_LEN = 32
) (
	input  wire                  clock,
	input  wire                  reset_i,
	input  wire                  clint_arvalid_i,
	input  wire [ADDR_LEN-1:0]   clint_araddr_i,
	output logic                 clint_arready_o,
	output logic                 clint_rvalid_o,
	output logic [DATA_LEN-1:0]  clint_rdata_o,
	output logic [1:0]           clint_rresp_o,
	output logic                 clint_rlast_o,
	input  wire                  clint_rready_i
);

	logic [2*DATA_LEN-1:0] mtime;
	logic [ADDR_LEN-1:0]   rd_off;
	logic                  ar_fire;

	assign rd_off = (clint_araddr_i - ADDR_LEN'(soc_pkg::CLINT_BASE))
		& ADDR_LEN'(soc_pkg::CLINT_SPAN_MASK);

	assign clint_arready_o = !clint_rvalid_o;
	assign ar_fire         = clint_arvalid_i && clint_arready_o;
	assign clint_rresp_o   = soc_pkg::AXI_RESP_OKAY;
	assign clint_rlast_o   = clint_rvalid_o;

	// Free-running cycle counter
	always_ff @(posedge clock) begin
		if (reset_i) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			clint_rvalid_o <= 1'b0;
		end else if (ar_fire) begin
			clint_rvalid_o <= 1'b1;
		end else if (clint_rready_i) begin
			clint_rvalid_o <= 1'b0;
		end
	end

	// Any offset but the high one returns the low word
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			if (rd_off == ADDR_LEN'(soc_pkg::MTIME_HI_OFF)) begin
				clint_rdata_o <= mtime[2*DATA_LEN-1:DATA_LEN];
			end else begin
				clint_rdata_o <= mtime[DATA_LEN-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mem_access_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctl #(
	parameter int ADDR_LEN = 32,
	parameter int DATA_LEN = 32
) (
	input  wire                    clock,
	input  wire                    reset_i,
	// Instruction fetch
	input  wire                    inst_psel_i,
	input  wire [ADDR_LEN-1:0]     inst_paddr_i,
	input  wire [7:0]              inst_plen_i,
	input  wire [2:0]              inst_psize_i,
	output logic                   inst_pvalid_o,
	output logic [DATA_LEN-1:0]    inst_prdata_o,
	output logic                   inst_plast_o,
	output logic [1:0]             inst_presp_o,
	// Data read
	input  wire                    data_prsel_i,
	input  wire [ADDR_LEN-1:0]     data_praddr_i,
	input  wire [2:0]              data_prsize_i,
	output logic                   data_prvalid_o,
	output logic [DATA_LEN-1:0]    data_prdata_o,
	output logic [1:0]             data_prresp_o,
	// Data write
	input  wire                    data_pwsel_i,
	input  wire [ADDR_LEN-1:0]     data_pwaddr_i,
	input  wire [DATA_LEN-1:0]     data_pwdata_i,
	input  wire [DATA_LEN/8-1:0]   data_pwstrb_i,
	input  wire [2:0]              data_pwsize_i,
	output logic                   data_pwrdy_o,
	output logic [1:0]             data_pwresp_o,
	// AXI master
	output logic                   ctl_arvalid_o,
	output logic [ADDR_LEN-1:0]    ctl_araddr_o,
	output logic [7:0]             ctl_arlen_o,
	output logic [2:0]             ctl_arsize_o,
	input  wire                    ctl_arready_i,
	input  wire                    ctl_rvalid_i,
	input  wire [DATA_LEN-1:0]     ctl_rdata_i,
	input  wire [1:0]              ctl_rresp_i,
	input  wire                    ctl_rlast_i,
	output logic                   ctl_rready_o,
	output logic                   ctl_awvalid_o,
	output logic [ADDR_LEN-1:0]    ctl_awaddr_o,
	output logic [2:0]             ctl_awsize_o,
	input  wire                    ctl_awready_i,
	output logic                   ctl_wvalid_o,
	output logic [DATA_LEN-1:0]    ctl_wdata_o,
	output logic [DATA_LEN/8-1:0]  ctl_wstrb_o,
	output logic                   ctl_wlast_o,
	input  wire                    ctl_wready_i,
	input  wire                    ctl_bvalid_i,
	input  wire [1:0]              ctl_bresp_i,
	output logic                   ctl_bready_o
);

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_RADDR = 3'd1;
	localparam logic [2:0] S_RDATA = 3'd2;
	localparam logic [2:0] S_WADDR = 3'd3;
	localparam logic [2:0] S_WRESP = 3'd4;
	localparam logic [2:0] S_DONE  = 3'd5;

	logic [2:0]            state;
	logic                  own_inst;
	logic                  aw_done;
	logic                  w_done;
	logic [ADDR_LEN-1:0]   req_addr;
	logic [7:0]            req_len;
	logic [2:0]            req_size;
	logic [DATA_LEN-1:0]   req_wdata;
	logic [DATA_LEN/8-1:0] req_wstrb;
	logic                  ar_fire;
	logic                  r_fire;
	logic                  aw_fire;
	logic                  w_fire;
	logic                  b_fire;

	assign ctl_arvalid_o = (state == S_RADDR);
	assign ctl_araddr_o  = req_addr;
	assign ctl_arlen_o   = req_len;
	assign ctl_arsize_o  = req_size;
	assign ctl_rready_o  = (state == S_RDATA);
	assign ctl_awvalid_o = (state == S_WADDR) && !aw_done;
	assign ctl_awaddr_o  = req_addr;
	assign ctl_awsize_o  = req_size;
	assign ctl_wvalid_o  = (state == S_WADDR) && !w_done;
	assign ctl_wdata_o   = req_wdata;
	assign ctl_wstrb_o   = req_wstrb;
	assign ctl_wlast_o   = 1'b1;
	assign ctl_bready_o  = (state == S_WRESP);

	assign ar_fire = ctl_arvalid_o && ctl_arready_i;
	assign r_fire  = ctl_rvalid_i && ctl_rready_o;
	assign aw_fire = ctl_awvalid_o && ctl_awready_i;
	assign w_fire  = ctl_wvalid_o && ctl_wready_i;
	assign b_fire  = ctl_bvalid_i && ctl_bready_o;

	// Write beats read, read beats fetch
	always_ff @(posedge clock) begin
		if (reset_i) begin
			state    <= S_IDLE;
			own_inst <= 1'b0;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					aw_done <= 1'b0;
					w_done  <= 1'b0;
					if (data_pwsel_i) begin
						state <= S_WADDR;
					end else if (data_prsel_i) begin
						state    <= S_RADDR;
						own_inst <= 1'b0;
					end else if (inst_psel_i) begin
						state    <= S_RADDR;
						own_inst <= 1'b1;
					end
				end
				S_RADDR: begin
					if (ar_fire) begin
						state <= S_RDATA;
					end
				end
				S_RDATA: begin
					if (r_fire && ctl_rlast_i) begin
						state <= S_DONE;
					end
				end
				S_WADDR: begin
					if (aw_fire) begin
						aw_done <= 1'b1;
					end
					if (w_fire) begin
						w_done <= 1'b1;
					end
					if ((aw_done || aw_fire) && (w_done || w_fire)) begin
						state <= S_WRESP;
					end
				end
				S_WRESP: begin
					if (b_fire) begin
						state <= S_DONE;
					end
				end
				// Requester drops sel during this cycle
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_IDLE) begin
			req_wdata <= data_pwdata_i;
			req_wstrb <= data_pwstrb_i;
			if (data_pwsel_i) begin
				req_addr <= data_pwaddr_i;
				req_size <= data_pwsize_i;
				req_len  <= 8'd0;
			end else if (data_prsel_i) begin
				req_addr <= data_praddr_i;
				req_size <= data_prsize_i;
				req_len  <= 8'd0;
			end else begin
				req_addr <= inst_paddr_i;
				req_size <= inst_psize_i;
				req_len  <= inst_plen_i;
			end
		end
	end

	// One pulse per beat, one cycle after the transfer
	always_ff @(posedge clock) begin
		if (reset_i) begin
			inst_pvalid_o  <= 1'b0;
			inst_plast_o   <= 1'b0;
			data_prvalid_o <= 1'b0;
			data_pwrdy_o   <= 1'b0;
			inst_presp_o   <= soc_pkg::AXI_RESP_OKAY;
			data_prresp_o  <= soc_pkg::AXI_RESP_OKAY;
			data_pwresp_o  <= soc_pkg::AXI_RESP_OKAY;
		end else begin
			inst_pvalid_o  <= r_fire && own_inst;
			inst_plast_o   <= r_fire && own_inst && ctl_rlast_i;
			data_prvalid_o <= r_fire && !own_inst;
			data_pwrdy_o   <= b_fire;
			if (r_fire && own_inst) begin
				inst_presp_o <= ctl_rresp_i;
			end
			if (r_fire && !own_inst) begin
				data_prresp_o <= ctl_rresp_i;
			end
			if (b_fire) begin
				data_pwresp_o <= ctl_bresp_i;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (r_fire && own_inst) begin
			inst_prdata_o <= ctl_rdata_i;
		end
		if (r_fire && !own_inst) begin
			data_prdata_o <= ctl_rdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
	parameter int ADDR_LEN = 32,
	parameter int DATA_LEN = 32
) (
	input  wire                    clock,
	input  wire                    reset_i,
	// CPU instruction port
	input  wire                    inst_psel_i,
	input  wire [ADDR_LEN-1:0]     inst_paddr_i,
	input  wire [7:0]              inst_plen_i,
	input  wire [2:0]              inst_psize_i,
	output logic                   inst_pvalid_o,
	output logic [DATA_LEN-1:0]    inst_prdata_o,
	output logic                   inst_plast_o,
	output logic [1:0]             inst_presp_o,
	// CPU data ports
	input  wire                    data_prsel_i,
	input  wire [ADDR_LEN-1:0]     data_praddr_i,
	input  wire [2:0]              data_prsize_i,
	output logic                   data_prvalid_o,
	output logic [DATA_LEN-1:0]    data_prdata_o,
	output logic [1:0]             data_prresp_o,
	input  wire                    data_pwsel_i,
	input  wire [ADDR_LEN-1:0]     data_pwaddr_i,
	input  wire [DATA_LEN-1:0]     data_pwdata_i,
	input  wire [DATA_LEN/8-1:0]   data_pwstrb_i,
	input  wire [2:0]              data_pwsize_i,
	output logic                   data_pwrdy_o,
	output logic [1:0]             data_pwresp_o,
	// External master port
	output logic                   io_master_arvalid_o,
	output logic [ADDR_LEN-1:0]    io_master_araddr_o,
	output logic [7:0]             io_master_arlen_o,
	output logic [2:0]             io_master_arsize_o,
	input  wire                    io_master_arready_i,
	input  wire                    io_master_rvalid_i,
	input  wire [DATA_LEN-1:0]     io_master_rdata_i,
	input  wire [1:0]              io_master_rresp_i,
	input  wire                    io_master_rlast_i,
	output logic                   io_master_rready_o,
	output logic                   io_master_awvalid_o,
	output logic [ADDR_LEN-1:0]    io_master_awaddr_o,
	output logic [2:0]             io_master_awsize_o,
	input  wire                    io_master_awready_i,
	output logic                   io_master_wvalid_o,
	output logic [DATA_LEN-1:0]    io_master_wdata_o,
	output logic [DATA_LEN/8-1:0]  io_master_wstrb_o,
	output logic                   io_master_wlast_o,
	input  wire                    io_master_wready_i,
	input  wire                    io_master_bvalid_i,
	input  wire [1:0]              io_master_bresp_i,
	output logic                   io_master_bready_o
);

	// Controller to crossbar
	logic                  ctl_arvalid;
	logic [ADDR_LEN-1:0]   ctl_araddr;
	logic [7:0]            ctl_arlen;
	logic [2:0]            ctl_arsize;
	logic                  ctl_arready;
	logic                  ctl_rvalid;
	logic [DATA_LEN-1:0]   ctl_rdata;
	logic [1:0]            ctl_rresp;
	logic                  ctl_rlast;
	logic                  ctl_rready;
	logic                  ctl_awvalid;
	logic [ADDR_LEN-1:0]   ctl_awaddr;
	logic [2:0]            ctl_awsize;
	logic                  ctl_awready;
	logic                  ctl_wvalid;
	logic [DATA_LEN-1:0]   ctl_wdata;
	logic [DATA_LEN/8-1:0] ctl_wstrb;
	logic                  ctl_wlast;
	logic                  ctl_wready;
	logic                  ctl_bvalid;
	logic [1:0]            ctl_bresp;
	logic                  ctl_bready;

	// Crossbar to timer
	logic                  clint_arvalid;
	logic [ADDR_LEN-1:0]   clint_araddr;
	logic                  clint_arready;
	logic                  clint_rvalid;
	logic [DATA_LEN-1:0]   clint_rdata;
	logic [1:0]            clint_rresp;
	logic                  clint_rlast;
	logic                  clint_rready;

	mem_access_ctl #(
		.ADDR_LEN (ADDR_LEN),
		.DATA_LEN (DATA_LEN)
	) u_mem_access_ctl (
		.*,
		.ctl_arvalid_o (ctl_arvalid),
		.ctl_araddr_o  (ctl_araddr),
		.ctl_arlen_o   (ctl_arlen),
		.ctl_arsize_o  (ctl_arsize),
		.ctl_arready_i (ctl_arready),
		.ctl_rvalid_i  (ctl_rvalid),
		.ctl_rdata_i   (ctl_rdata),
		.ctl_rresp_i   (ctl_rresp),
		.ctl_rlast_i   (ctl_rlast),
		.ctl_rready_o  (ctl_rready),
		.ctl_awvalid_o (ctl_awvalid),
		.ctl_awaddr_o  (ctl_awaddr),
		.ctl_awsize_o  (ctl_awsize),
		.ctl_awready_i (ctl_awready),
		.ctl_wvalid_o  (ctl_wvalid),
		.ctl_wdata_o   (ctl_wdata),
		.ctl_wstrb_o   (ctl_wstrb),
		.ctl_wlast_o   (ctl_wlast),
		.ctl_wready_i  (ctl_wready),
		.ctl_bvalid_i  (ctl_bvalid),
		.ctl_bresp_i   (ctl_bresp),
		.ctl_bready_o  (ctl_bready)
	);

	axi_xbar #(
		.ADDR_LEN (ADDR_LEN),
		.DATA_LEN (DATA_LEN)
	) u_axi_xbar (
		.*,
		.ctl_arvalid_i   (ctl_arvalid),
		.ctl_araddr_i    (ctl_araddr),
		.ctl_arlen_i     (ctl_arlen),
		.ctl_arsize_i    (ctl_arsize),
		.ctl_arready_o   (ctl_arready),
		.ctl_rvalid_o    (ctl_rvalid),
		.ctl_rdata_o     (ctl_rdata),
		.ctl_rresp_o     (ctl_rresp),
		.ctl_rlast_o     (ctl_rlast),
		.ctl_rready_i    (ctl_rready),
		.ctl_awvalid_i   (ctl_awvalid),
		.ctl_awaddr_i    (ctl_awaddr),
		.ctl_awsize_i    (ctl_awsize),
		.ctl_awready_o   (ctl_awready),
		.ctl_wvalid_i    (ctl_wvalid),
		.ctl_wdata_i     (ctl_wdata),
		.ctl_wstrb_i     (ctl_wstrb),
		.ctl_wlast_i     (ctl_wlast),
		.ctl_wready_o    (ctl_wready),
		.ctl_bvalid_o    (ctl_bvalid),
		.ctl_bresp_o     (ctl_bresp),
		.ctl_bready_i    (ctl_bready),
		.clint_arvalid_o (clint_arvalid),
		.clint_araddr_o  (clint_araddr),
		.clint_arready_i (clint_arready),
		.clint_rvalid_i  (clint_rvalid),
		.clint_rdata_i   (clint_rdata),
		.clint_rresp_i   (clint_rresp),
		.clint_rlast_i   (clint_rlast),
		.clint_rready_o  (clint_rready)
	);

	clint_timer #(
		.ADDR_LEN (ADDR_LEN),
		.DATA_LEN (DATA_LEN)
	) u_clint_timer (
		.clock           (clock),
		.reset_i         (reset_i),
		.clint_arvalid_i (clint_arvalid),
		.clint_araddr_i  (clint_araddr),
		.clint_arready_o (clint_arready),
		.clint_rvalid_o  (clint_rvalid),
		.clint_rdata_o   (clint_rdata),
		.clint_rresp_o   (clint_rresp),
		.clint_rlast_o   (clint_rlast),
		.clint_rready_i  (clint_rready)
	);

endmodule

`default_nettype wire

// ==== rtl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// AXI response codes
	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	// Core-local timer region
	localparam logic [31:0] CLINT_BASE      = 32'h0200_0000;
	localparam logic [31:0] CLINT_SPAN_MASK = 32'h0000_FFFF;

	// Upper mtime word, the lower one sits at offset 0
	localparam logic [31:0] MTIME_HI_OFF    = 32'd4;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_mem_subsys \
	--Mdir "$BUILD_DIR" \
	-o Vtb_mem_subsys \
	-f tb.f

"./$BUILD_DIR/Vtb_mem_subsys" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^All checks passed$" "$LOG"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// ==== tb.f ====
rtl/soc_pkg.sv
rtl/mem_access_ctl.sv
rtl/axi_xbar.sv
rtl/clint_timer.sv
rtl/mem_subsys_top.sv
verif/axi_slave_model.sv
verif/tb_mem_subsys.sv

// ==== verif/axi_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model (
	input  wire         clock,
	// Read address and data
	input  wire         arvalid_i,
	input  wire  [31:0] araddr_i,
	input  wire  [7:0]  arlen_i,
	output logic        arready_o,
	output logic        rvalid_o,
	output logic [31:0] rdata_o,
	output logic [1:0]  rresp_o,
	output logic        rlast_o,
	input  wire         rready_i,
	// Write address, data and response
	input  wire         awvalid_i,
	input  wire  [31:0] awaddr_i,
	output logic        awready_o,
	input  wire         wvalid_i,
	input  wire  [31:0] wdata_i,
	input  wire  [3:0]  wstrb_i,
	output logic        wready_o,
	output logic        bvalid_o,
	output logic [1:0]  bresp_o,
	input  wire         bready_i
);

	logic [31:0] mem [logic [31:0]];
	logic [31:0] rd_rng;
	logic [31:0] wr_rng;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Unwritten words hold a pattern of their own address
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		if (mem.exists(a)) begin
			return mem[a];
		end else begin
			return a ^ 32'hA5A5_0000;
		end
	endfunction

	// Upper half of the address space is the error region
	function automatic logic [1:0] resp_for(input logic [31:0] addr);
		if (addr[31]) begin
			return soc_pkg::AXI_RESP_SLVERR;
		end else begin
			return soc_pkg::AXI_RESP_OKAY;
		end
	endfunction

	// Waits whole cycles, staying 1 ns past the edge
	task automatic idle_cycles(input logic [1:0] n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin : read_side
		logic [31:0] addr;
		int          beats;
		arready_o = 1'b0;
		rvalid_o  = 1'b0;
		rdata_o   = '0;
		rresp_o   = '0;
		rlast_o   = 1'b0;
		rd_rng    = 32'd25418;
		forever begin
			@(posedge clock);
			while (!arvalid_i) @(posedge clock);
			#1;
			rd_rng = xorshift32(rd_rng);
			idle_cycles(rd_rng[1:0]);
			arready_o = 1'b1;
			@(posedge clock);
			addr  = araddr_i;
			beats = {24'd0, arlen_i} + 1;
			#1;
			arready_o = 1'b0;
			for (int i = 0; i < beats; i++) begin
				rd_rng = xorshift32(rd_rng);
				idle_cycles(rd_rng[1:0]);
				rvalid_o = 1'b1;
				rdata_o  = read_word(addr + 4 * i);
				rresp_o  = resp_for(addr);
				rlast_o  = (i == beats - 1);
				@(posedge clock);
				while (!rready_i) @(posedge clock);
				#1;
				rvalid_o = 1'b0;
				rlast_o  = 1'b0;
			end
		end
	end

	initial begin : write_side
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] word;
		awready_o = 1'b0;
		wready_o  = 1'b0;
		bvalid_o  = 1'b0;
		bresp_o   = '0;
		wr_rng    = xorshift32(32'd25418);
		forever begin
			@(posedge clock);
			while (!(awvalid_i && wvalid_i)) @(posedge clock);
			#1;
			wr_rng = xorshift32(wr_rng);
			idle_cycles(wr_rng[1:0]);
			awready_o = 1'b1;
			@(posedge clock);
			addr = awaddr_i;
			#1;
			awready_o = 1'b0;
			idle_cycles(wr_rng[3:2]);
			wready_o = 1'b1;
			@(posedge clock);
			data = wdata_i;
			strb = wstrb_i;
			#1;
			wready_o = 1'b0;
			// Error region drops the write
			if (!addr[31]) begin
				word = read_word(addr);
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) begin
						word[8*b +: 8] = data[8*b +: 8];
					end
				end
				mem[{addr[31:2], 2'b00}] = word;
			end
			idle_cycles(wr_rng[5:4]);
			bvalid_o = 1'b1;
			bresp_o  = resp_for(addr);
			@(posedge clock);
			while (!bready_i) @(posedge clock);
			#1;
			bvalid_o = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

	localparam int          CLK_PERIOD = 40;
	localparam int          TEST_COUNT = 5;
	localparam logic [31:0] TIMER_GAP  = 32'd20;

	logic        clock;
	logic        reset_i;
	logic        inst_psel_i;
	logic [31:0] inst_paddr_i;
	logic [7:0]  inst_plen_i;
	logic [2:0]  inst_psize_i;
	logic        inst_pvalid_o;
	logic [31:0] inst_prdata_o;
	logic        inst_plast_o;
	logic [1:0]  inst_presp_o;
	logic        data_prsel_i;
	logic [31:0] data_praddr_i;
	logic [2:0]  data_prsize_i;
	logic        data_prvalid_o;
	logic [31:0] data_prdata_o;
	logic [1:0]  data_prresp_o;
	logic        data_pwsel_i;
	logic [31:0] data_pwaddr_i;
	logic [31:0] data_pwdata_i;
	logic [3:0]  data_pwstrb_i;
	logic [2:0]  data_pwsize_i;
	logic        data_pwrdy_o;
	logic [1:0]  data_pwresp_o;
	logic        io_master_arvalid_o;
	logic [31:0] io_master_araddr_o;
	logic [7:0]  io_master_arlen_o;
	logic [2:0]  io_master_arsize_o;
	logic        io_master_arready_i;
	logic        io_master_rvalid_i;
	logic [31:0] io_master_rdata_i;
	logic [1:0]  io_master_rresp_i;
	logic        io_master_rlast_i;
	logic        io_master_rready_o;
	logic        io_master_awvalid_o;
	logic [31:0] io_master_awaddr_o;
	logic [2:0]  io_master_awsize_o;
	logic        io_master_awready_i;
	logic        io_master_wvalid_o;
	logic [31:0] io_master_wdata_o;
	logic [3:0]  io_master_wstrb_o;
	logic        io_master_wlast_o;
	logic        io_master_wready_i;
	logic        io_master_bvalid_i;
	logic [1:0]  io_master_bresp_i;
	logic        io_master_bready_o;

	int errors       = 0;
	int ext_ar_count = 0;

	mem_subsys_top #(
		.ADDR_LEN (32),
		.DATA_LEN (32)
	) UUT (.*);

	axi_slave_model u_ext_mem (
		.clock     (clock),
		.arvalid_i (io_master_arvalid_o),
		.araddr_i  (io_master_araddr_o),
		.arlen_i   (io_master_arlen_o),
		.arready_o (io_master_arready_i),
		.rvalid_o  (io_master_rvalid_i),
		.rdata_o   (io_master_rdata_i),
		.rresp_o   (io_master_rresp_i),
		.rlast_o   (io_master_rlast_i),
		.rready_i  (io_master_rready_o),
		.awvalid_i (io_master_awvalid_o),
		.awaddr_i  (io_master_awaddr_o),
		.awready_o (io_master_awready_i),
		.wvalid_i  (io_master_wvalid_o),
		.wdata_i   (io_master_wdata_o),
		.wstrb_i   (io_master_wstrb_o),
		.wready_o  (io_master_wready_i),
		.bvalid_o  (io_master_bvalid_i),
		.bresp_o   (io_master_bresp_i),
		.bready_i  (io_master_bready_o)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TEST_COUNT * 400 * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", TEST_COUNT * 400);
		$display("Checks failed");
		$finish;
	end

	// External requests, counted for the timer test
	// Size follows the port that owns the request, data over fetch
	always @(negedge clock) begin
		logic [2:0] exp_arsize;
		exp_arsize = data_prsel_i ? data_prsize_i : inst_psize_i;
		if (io_master_arvalid_o) begin
			ext_ar_count = ext_ar_count + 1;
			if (io_master_arsize_o !== exp_arsize) begin
				report_mismatch("io_master_arsize_o", 32'(io_master_arsize_o),
					32'(exp_arsize));
			end
		end
		if (io_master_awvalid_o && io_master_awsize_o !== data_pwsize_i) begin
			report_mismatch("io_master_awsize_o", 32'(io_master_awsize_o),
				32'(data_pwsize_i));
		end
		if (io_master_wvalid_o && io_master_wlast_o !== 1'b1) begin
			report_mismatch("io_master_wlast_o", 32'(io_master_wlast_o), 32'd1);
		end
	end

	// Word value of untouched external memory
	function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("At %0t ns: %s", $time, what);
	endtask

	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	task automatic data_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		data_praddr_i = addr;
		data_prsize_i = 3'd2;
		data_prsel_i  = 1'b1;
		tick();
		while (!data_prvalid_o) tick();
		data = data_prdata_o;
		resp = data_prresp_o;
		data_prsel_i = 1'b0;
		tick();
	endtask

	task automatic data_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		data_pwaddr_i = addr;
		data_pwdata_i = data;
		data_pwstrb_i = strb;
		data_pwsize_i = 3'd2;
		data_pwsel_i  = 1'b1;
		tick();
		while (!data_pwrdy_o) tick();
		resp = data_pwresp_o;
		data_pwsel_i = 1'b0;
		tick();
	endtask

	task automatic fetch_burst_test();
		logic [31:0] base;
		int          beats;
		base  = 32'h0000_1000;
		beats = 0;
		inst_paddr_i = base;
		inst_plen_i  = 8'd3;
		inst_psize_i = 3'd2;
		inst_psel_i  = 1'b1;
		while (beats < 4) begin
			tick();
			if (inst_pvalid_o) begin
				if (inst_prdata_o !== mem_pattern(base + 4 * beats)) begin
					report_mismatch("inst_prdata_o", inst_prdata_o,
						mem_pattern(base + 4 * beats));
				end
				if (inst_plast_o !== (beats == 3)) begin
					report_mismatch("inst_plast_o", 32'(inst_plast_o), 32'(beats == 3));
				end
				if (inst_presp_o !== soc_pkg::AXI_RESP_OKAY) begin
					report_mismatch("inst_presp_o", 32'(inst_presp_o),
						32'(soc_pkg::AXI_RESP_OKAY));
				end
				beats++;
			end
		end
		inst_psel_i = 1'b0;
		repeat (8) begin
			tick();
			if (inst_pvalid_o) begin
				report_failure("fetch returned a beat after the last one");
			end
		end
	endtask

	task automatic write_read_test();
		logic [31:0] addr;
		logic [31:0] old_word;
		logic [31:0] new_word;
		logic [31:0] exp_word;
		logic [31:0] rd_word;
		logic [1:0]  resp;
		addr     = 32'h0000_2040;
		old_word = mem_pattern(addr);
		new_word = 32'h1122_3344;
		// Lanes 0 and 2 take the new bytes
		exp_word = {old_word[31:24], new_word[23:16], old_word[15:8], new_word[7:0]};
		data_write(addr, new_word, 4'b0101, resp);
		if (resp !== soc_pkg::AXI_RESP_OKAY) begin
			report_mismatch("data_pwresp_o", 32'(resp), 32'(soc_pkg::AXI_RESP_OKAY));
		end
		data_read(addr, rd_word, resp);
		if (rd_word !== exp_word) begin
			report_mismatch("data_prdata_o", rd_word, exp_word);
		end
		if (resp !== soc_pkg::AXI_RESP_OKAY) begin
			report_mismatch("data_prresp_o", 32'(resp), 32'(soc_pkg::AXI_RESP_OKAY));
		end
	endtask

	task automatic priority_test();
		logic [31:0] rd_addr;
		logic [31:0] if_addr;
		int          inst_beats;
		logic        data_seen;
		rd_addr    = 32'h0000_3000;
		if_addr    = 32'h0000_4000;
		inst_beats = 0;
		data_seen  = 1'b0;
		data_praddr_i = rd_addr;
		data_prsize_i = 3'd2;
		inst_paddr_i  = if_addr;
		inst_plen_i   = 8'd1;
		inst_psize_i  = 3'd2;
		data_prsel_i  = 1'b1;
		inst_psel_i   = 1'b1;
		while (inst_beats < 2) begin
			tick();
			if (data_prvalid_o) begin
				data_seen = 1'b1;
				if (data_prdata_o !== mem_pattern(rd_addr)) begin
					report_mismatch("data_prdata_o", data_prdata_o, mem_pattern(rd_addr));
				end
				data_prsel_i = 1'b0;
			end
			if (inst_pvalid_o) begin
				if (!data_seen) begin
					report_failure("fetch data arrived before the data read result");
				end
				if (inst_prdata_o !== mem_pattern(if_addr + 4 * inst_beats)) begin
					report_mismatch("inst_prdata_o", inst_prdata_o,
						mem_pattern(if_addr + 4 * inst_beats));
				end
				inst_beats++;
			end
		end
		inst_psel_i = 1'b0;
		tick();
	endtask

	task automatic timer_test();
		logic [31:0] lo_first;
		logic [31:0] lo_second;
		logic [31:0] hi_word;
		logic [1:0]  resp;
		int          ar_before;
		ar_before = ext_ar_count;
		data_read(soc_pkg::CLINT_BASE, lo_first, resp);
		if (resp !== soc_pkg::AXI_RESP_OKAY) begin
			report_mismatch("data_prresp_o", 32'(resp), 32'(soc_pkg::AXI_RESP_OKAY));
		end
		repeat (TIMER_GAP) tick();
		data_read(soc_pkg::CLINT_BASE, lo_second, resp);
		if (lo_second <= lo_first) begin
			report_failure("mtime did not increase between two reads");
		end else if (lo_second - lo_first < TIMER_GAP) begin
			report_failure("mtime advanced by fewer cycles than were waited");
		end
		data_read(soc_pkg::CLINT_BASE + soc_pkg::MTIME_HI_OFF, hi_word, resp);
		if (hi_word !== 32'd0) begin
			report_mismatch("data_prdata_o", hi_word, 32'd0);
		end
		if (ext_ar_count != ar_before) begin
			report_failure("a timer read reached the external master port");
		end
	endtask

	task automatic error_resp_test();
		logic [31:0] rd_word;
		logic [1:0]  resp;
		data_read(32'h8000_0010, rd_word, resp);
		if (resp !== soc_pkg::AXI_RESP_SLVERR) begin
			report_mismatch("data_prresp_o", 32'(resp), 32'(soc_pkg::AXI_RESP_SLVERR));
		end
		data_write(32'h8000_0010, 32'hDEAD_BEEF, 4'b1111, resp);
		if (resp !== soc_pkg::AXI_RESP_SLVERR) begin
			report_mismatch("data_pwresp_o", 32'(resp), 32'(soc_pkg::AXI_RESP_SLVERR));
		end
	endtask

	initial begin : main
		reset_i       = 1'b1;
		inst_psel_i   = 1'b0;
		inst_paddr_i  = '0;
		inst_plen_i   = '0;
		inst_psize_i  = '0;
		data_prsel_i  = 1'b0;
		data_praddr_i = '0;
		data_prsize_i = '0;
		data_pwsel_i  = 1'b0;
		data_pwaddr_i = '0;
		data_pwdata_i = '0;
		data_pwstrb_i = '0;
		data_pwsize_i = '0;
		repeat (5) @(posedge clock);
		#1;
		reset_i = 1'b0;
		fetch_burst_test();
		write_read_test();
		priority_test();
		timer_test();
		error_resp_test();
		$display("Errors: %0d in %0d tests", errors, TEST_COUNT);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
